/* matinv.f */
rtl/matinv_pkg.sv
rtl/matinv_capture.sv
rtl/det_unit.sv
rtl/seq_divider.sv
rtl/block_inverter.sv
rtl/matinv_assemble.sv
rtl/matinv_top.sv
tb/matinv_tb.sv

/* tb/matinv_tb.sv */
`timescale 1ns/1ps

module matinv_tb
    import matinv_pkg::*;
();

    localparam int   N_RUNS     = 25;                       // upper bound on inversions
    localparam int   MAX_CYCLES = 2 * N_RUNS * INV_LATENCY + 350;
    localparam fix_t ONE        = 32'h0001_0000;            // 1.0 in q16.16

    logic             clk = 1'b0;
    logic             rst_n;
    logic             start;
    blk_arr_t         blocks;
    logic             ready;
    logic             done;
    mat_t             inv_matrix;
    logic [N_BLK-1:0] singular;

    int          errors     = 0;
    int          runs       = 0;
    int          done_count = 0;
    int          cycle      = 0;
    logic        done_q     = 1'b0;
    logic [31:0] lcg_state  = 32'h741d_d9ae;

    matinv_top matinv_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .blocks     (blocks),
        .ready      (ready),
        .done       (done),
        .inv_matrix (inv_matrix),
        .singular   (singular)
    );

    always #5 clk = ~clk;

    // --------------------
    // watchdog and done monitor
    // --------------------
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout waiting for done");
            $display("errors: %0d", errors + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(done && done_q)) else begin
                errors++;
                $display("done stayed high for more than one cycle");
            end
            if (done) done_count++;
        end
        done_q = done;
    end

    // --------------------
    // stimulus helpers
    // --------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // a, d in [1.0, 8.0), |x| < 0.5 so det stays well above zero
    function automatic blk_arr_t random_blocks();
        blk_arr_t b;
        for (int k = 0; k < N_BLK; k++) begin
            b[k].a = fix_t'(ONE + ((next_rand() >> 4) % 32'h0007_0000));
            b[k].d = fix_t'(ONE + ((next_rand() >> 4) % 32'h0007_0000));
            b[k].x = fix_t'(((next_rand() >> 4) % 32'h0001_0000) - 32'h0000_8000);
        end
        return b;
    endfunction

    // --------------------
    // reference model
    // --------------------
    function automatic fix_t model_det(fix_t a, fix_t d, fix_t x);
        longint p;
        p = longint'(a) * longint'(d) - longint'(x) * longint'(x);
        return fix_t'(p >>> FRAC_W);        // truncated to 32 bits
    endfunction

    function automatic fix_t model_div(fix_t num, fix_t den);
        longint q;
        q = (longint'(num) <<< FRAC_W) / longint'(den);   // rounds toward zero
        return fix_t'(q);
    endfunction

    task automatic model_inverse(input blk_arr_t b, output mat_t m,
                                 output logic [N_BLK-1:0] s);
        fix_t det;
        m = '0;
        for (int k = 0; k < N_BLK; k++) begin
            det  = model_det(b[k].a, b[k].d, b[k].x);
            s[k] = (det == 0);
            if (det != 0) begin             // singular blocks stay zero
                m[k][k]                 = model_div(b[k].d, det);
                m[k][k + N_BLK]         = -model_div(b[k].x, det);
                m[k + N_BLK][k]         = m[k][k + N_BLK];
                m[k + N_BLK][k + N_BLK] = model_div(b[k].a, det);
            end
        end
    endtask

    // --------------------
    // one inversion, optionally with start pulses while busy
    // --------------------
    task automatic run_inversion(input string name, input blk_arr_t b, input bit poke);
        int               lat;
        mat_t             exp_m;
        logic [N_BLK-1:0] exp_s;
        model_inverse(b, exp_m, exp_s);
        @(negedge clk);
        blocks = b;
        start  = 1'b1;
        @(negedge clk);
        start = 1'b0;
        lat   = 1;
        while (!done) begin
            // early pulse before the divider load, late one while the channels finish
            if (poke && (lat == 2 || lat == INV_LATENCY - 1)) begin
                assert (!ready) else begin
                    errors++;
                    $display("%s: ready high while a run is in flight", name);
                end
                blocks = random_blocks();   // must be ignored
                start  = 1'b1;
            end else begin
                start = 1'b0;
            end
            @(negedge clk);
            lat++;
        end
        start = 1'b0;
        runs++;
        assert (lat == INV_LATENCY) else begin
            errors++;
            $display("** Error %s: latency expected %0d, got %0d", name, INV_LATENCY, lat);
        end
        assert (singular === exp_s) else begin
            errors++;
            $display("** Error %s: singular expected %b, got %b", name, exp_s, singular);
        end
        for (int i = 0; i < MAT_N; i++) begin
            for (int j = 0; j < MAT_N; j++) begin
                assert (inv_matrix[i][j] === exp_m[i][j]) else begin
                    errors++;
                    $display("** Error %s: entry (%0d,%0d) expected %h, got %h",
                             name, i, j, exp_m[i][j], inv_matrix[i][j]);
                end
            end
        end
        assert (!ready) else begin
            errors++;
            $display("%s: ready already high in the done cycle", name);
        end
        @(negedge clk);
        assert (ready) else begin
            errors++;
            $display("%s: ready not high the cycle after done", name);
        end
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        blk_arr_t b;
        rst_n  = 1'b0;
        start  = 1'b0;
        blocks = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        assert (ready && !done && inv_matrix == '0 && singular == '0) else begin
            errors++;
            $display("outputs not in their reset state after reset");
        end

        for (int k = 0; k < N_BLK; k++) begin
            b[k].a = ONE;
            b[k].d = ONE;
            b[k].x = '0;
        end
        run_inversion("identity", b, 1'b0);

        for (int n = 0; n < 20; n++) begin
            run_inversion($sformatf("random_%0d", n), random_blocks(), 1'b0);
        end

        b      = random_blocks();
        b[1].a = 32'h0002_0000;             // a*d == x*x
        b[1].d = 32'h0002_0000;
        b[1].x = 32'h0002_0000;
        run_inversion("singular", b, 1'b0);

        run_inversion("start_busy", random_blocks(), 1'b1);

        // an ignored start would show up as an extra done here
        repeat (INV_LATENCY + 10) @(negedge clk);
        assert (done_count == runs) else begin
            errors++;
            $display("** Error done_count: expected %0d, got %0d", runs, done_count);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* rtl/matinv_top.sv */
`timescale 1ns/1ps

module matinv_top
    import matinv_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  blk_arr_t         blocks,
    output logic             ready,
    output logic             done,
    output mat_t             inv_matrix,
    output logic [N_BLK-1:0] singular
);

    logic             go;
    blk_arr_t         blk_q;
    blk_inv_arr_t     blk_res;
    logic [N_BLK-1:0] blk_done;

    matinv_capture matinv_capture_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .blocks (blocks),
        .done   (done),
        .ready  (ready),
        .go     (go),
        .blk_q  (blk_q)
    );

    // one channel per 2x2 block
    for (genvar k = 0; k < N_BLK; k++) begin : g_blk
        block_inverter block_inverter_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .go       (go),
            .blk      (blk_q[k]),
            .result   (blk_res[k]),
            .blk_done (blk_done[k])
        );
    end

    matinv_assemble matinv_assemble_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .blk_res    (blk_res),
        .blk_done   (blk_done),
        .inv_matrix (inv_matrix),
        .singular   (singular),
        .done       (done)
    );

endmodule

/* rtl/matinv_assemble.sv */
`timescale 1ns/1ps

module matinv_assemble
    import matinv_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  blk_inv_arr_t     blk_res,
    input  logic [N_BLK-1:0] blk_done,
    output mat_t             inv_matrix,
    output logic [N_BLK-1:0] singular,
    output logic             done
);

    mat_t             mat_next;
    logic [N_BLK-1:0] sing_next;
    logic             all_done;

    assign all_done = &blk_done;

    // --------------------
    // block placement
    // --------------------
    always_comb begin
        mat_next = '0;                  // everything off the blocks is zero
        for (int k = 0; k < N_BLK; k++) begin
            mat_next[k][k]                 = blk_res[k].inv_aa;
            mat_next[k][k + N_BLK]         = blk_res[k].inv_x;
            mat_next[k + N_BLK][k]         = blk_res[k].inv_x;   // symmetric pair
            mat_next[k + N_BLK][k + N_BLK] = blk_res[k].inv_dd;
            sing_next[k]                   = blk_res[k].singular;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inv_matrix <= '0;
            singular   <= '0;
            done       <= 1'b0;
        end else begin
            done <= all_done;           // single-cycle pulse
            if (all_done) begin
                inv_matrix <= mat_next;
                singular   <= sing_next;
            end
        end
    end

endmodule

/* rtl/block_inverter.sv */
`timescale 1ns/1ps

module block_inverter
    import matinv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     go,
    input  blk_t     blk,
    output blk_inv_t result,
    output logic     blk_done
);

    inv_state_t           state;
    logic [DET_CNT_W-1:0] det_cnt;
    fix_t                 det;
    fix_t                 divisor;
    logic                 det_zero;
    logic                 load;
    logic                 singular_q;
    fix_t                 q_aa;
    fix_t                 q_dd;
    fix_t                 q_x;
    logic [2:0]           q_valid;

    det_unit det_unit_i (
        .clk   (clk),
        .rst_n (rst_n),
        .blk   (blk),
        .det   (det)
    );

    // --------------------
    // zero check
    // --------------------
    assign det_zero = (det == '0);
    assign divisor  = det_zero ? fix_t'(1 << FRAC_W) : det;  // 1.0 keeps the timing
    assign load     = (state == DET) && (det_cnt == DET_CNT_W'(DET_LAT - 1));

    seq_divider div_aa_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .load           (load),
        .numerator      (blk.d),
        .denominator    (divisor),
        .quotient       (q_aa),
        .quotient_valid (q_valid[0])
    );

    seq_divider div_dd_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .load           (load),
        .numerator      (blk.a),
        .denominator    (divisor),
        .quotient       (q_dd),
        .quotient_valid (q_valid[1])
    );

    seq_divider div_x_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .load           (load),
        .numerator      (blk.x),
        .denominator    (divisor),
        .quotient       (q_x),
        .quotient_valid (q_valid[2])
    );

    // dividers run in lockstep
    assign blk_done = &q_valid;

    // quotients hold in the dividers, so this stays valid through HOLD
    assign result.inv_aa   = singular_q ? '0 : q_aa;
    assign result.inv_dd   = singular_q ? '0 : q_dd;
    assign result.inv_x    = singular_q ? '0 : -q_x;   // off-diagonal is negated
    assign result.singular = singular_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            det_cnt    <= '0;
            singular_q <= 1'b0;
        end else begin
            case (state)
                IDLE, HOLD: begin
                    if (go) begin
                        state   <= DET;
                        det_cnt <= '0;
                    end
                end
                DET: begin
                    det_cnt <= det_cnt + 1'b1;      // waits out the det pipeline
                    if (load) begin
                        state      <= DIV;
                        singular_q <= det_zero;
                    end
                end
                DIV: begin
                    if (blk_done) begin
                        state <= HOLD;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* rtl/seq_divider.sv */
`timescale 1ns/1ps

module seq_divider
    import matinv_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  fix_t numerator,
    input  fix_t denominator,
    output fix_t quotient,
    output logic quotient_valid
);

    logic              busy;
    logic [ITER_W-1:0] iter;
    logic              last;

    logic [NUM_W-1:0]  dividend;    // numerator bits out, quotient bits in
    logic [DATA_W-1:0] num_mag;
    logic [DATA_W-1:0] den_mag;
    logic [DATA_W-1:0] rem;
    logic              neg;

    logic [DATA_W:0]   rem_shift;
    logic [DATA_W+1:0] trial;
    logic              q_bit;
    logic [DATA_W-1:0] rem_next;
    logic [NUM_W-1:0]  q_full;

    // magnitude of -2^31 still fits as unsigned
    assign num_mag = numerator[DATA_W-1] ? -numerator : numerator;

    // --------------------
    // one restoring step
    // --------------------
    assign rem_shift = {rem, dividend[NUM_W-1]};
    assign trial     = {1'b0, rem_shift} - {2'b00, den_mag};
    assign q_bit     = ~trial[DATA_W+1];            // no borrow, subtract stands
    assign rem_next  = q_bit ? trial[DATA_W-1:0] : rem_shift[DATA_W-1:0];
    assign q_full    = {dividend[NUM_W-2:0], q_bit};

    assign last = busy && (iter == ITER_W'(DIV_ITERS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy           <= 1'b0;
            iter           <= '0;
            quotient_valid <= 1'b0;
        end else begin
            quotient_valid <= 1'b0;
            if (load) begin
                busy <= 1'b1;
                iter <= '0;
            end else if (busy) begin
                iter <= iter + 1'b1;
                if (last) begin
                    busy           <= 1'b0;
                    quotient_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dividend <= {num_mag, {FRAC_W{1'b0}}};  // numerator << FRAC_W
            den_mag  <= denominator[DATA_W-1] ? -denominator : denominator;
            neg      <= numerator[DATA_W-1] ^ denominator[DATA_W-1];
            rem      <= '0;
        end else if (busy) begin
            dividend <= q_full;
            rem      <= rem_next;
            if (last) begin
                // sign applied to the magnitude, so rounding is toward zero
                quotient <= neg ? -q_full[DATA_W-1:0] : q_full[DATA_W-1:0];
            end
        end
    end

endmodule

/* rtl/det_unit.sv */
`timescale 1ns/1ps

module det_unit
    import matinv_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  blk_t blk,
    output fix_t det
);

    logic signed [PROD_W-1:0] prod_ad;
    logic signed [PROD_W-1:0] prod_xx;
    logic signed [PROD_W-1:0] diff;

    // full-width difference, q32.32
    assign diff = prod_ad - prod_xx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_ad <= '0;
            prod_xx <= '0;
            det     <= '0;
        end else begin
            // --------------------
            // stage one
            // --------------------
            prod_ad <= blk.a * blk.d;   // sign-extended to 64 bits
            prod_xx <= blk.x * blk.x;

            // --------------------
            // stage two
            // --------------------
            // back to q16.16, arithmetic shift then truncate
            det <= diff[FRAC_W +: DATA_W];
        end
    end

endmodule

/* rtl/matinv_capture.sv */
`timescale 1ns/1ps

module matinv_capture
    import matinv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  blk_arr_t blocks,
    input  logic     done,
    output logic     ready,
    output logic     go,
    output blk_arr_t blk_q
);

    logic busy;
    logic accept;

    // start only counts while idle
    assign accept = start & ~busy;
    assign ready  = ~busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            go   <= 1'b0;
        end else begin
            go <= accept;               // one pulse per accepted start
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;           // ready again next cycle
            end
        end
    end

    // operands held for the whole run
    always_ff @(posedge clk) begin
        if (accept) begin
            blk_q <= blocks;
        end
    end

endmodule

/* rtl/matinv_pkg.sv */
package matinv_pkg;

    // --------------------
    // widths and sizes
    // --------------------
    localparam int DATA_W = 32;             // signed q16.16
    localparam int FRAC_W = 16;
    localparam int N_BLK  = 3;              // independent 2x2 blocks
    localparam int MAT_N  = 2 * N_BLK;
    localparam int PROD_W = 2 * DATA_W;     // full product width

    // divider runs one step per numerator bit after the shift
    localparam int DIV_ITERS = DATA_W + FRAC_W;
    localparam int NUM_W     = DIV_ITERS;
    localparam int ITER_W    = $clog2(DIV_ITERS);

    // --------------------
    // latency
    // --------------------
    localparam int DET_LAT     = 2;
    localparam int DET_CNT_W   = $clog2(DET_LAT);
    // capture + det + load + divide + assemble
    localparam int INV_LATENCY = DET_LAT + DIV_ITERS + 3;

    typedef logic signed [DATA_W-1:0] fix_t;

    typedef struct packed {
        fix_t a;        // entry (k,k)
        fix_t d;        // entry (k+3,k+3)
        fix_t x;        // cross term
    } blk_t;

    typedef blk_t [N_BLK-1:0] blk_arr_t;

    typedef struct packed {
        fix_t inv_aa;   // d/det
        fix_t inv_dd;   // a/det
        fix_t inv_x;    // -x/det
        logic singular;
    } blk_inv_t;

    typedef blk_inv_t [N_BLK-1:0] blk_inv_arr_t;

    typedef fix_t [MAT_N-1:0][MAT_N-1:0] mat_t;

    typedef enum logic [1:0] {
        IDLE,
        DET,
        DIV,
        HOLD
    } inv_state_t;

endpackage
